/* include/hdc_defines.svh */
`ifndef HDC_DEFINES_SVH
`define HDC_DEFINES_SVH

// hypervector width in bits, keep a multiple of 32
`define HDC_DIM 256
// 32-bit bus words per hypervector
`define HDC_WORDS (`HDC_DIM / 32)
// item memory depth, power of two
`define HDC_ITEMS 64
// queue depths
`define HDC_INSTR_DEPTH 4
`define HDC_RESULT_DEPTH 2

// wishbone byte addresses
`define HDC_A_CTRL 8'h00
`define HDC_A_ITEM_SEL 8'h04
`define HDC_A_COMMIT 8'h08
`define HDC_A_INSTR 8'h0C
`define HDC_A_STATUS 8'h10
`define HDC_A_STAGE 8'h40
`define HDC_A_RESULT 8'h80

`endif

/* logic/hdc_pkg.sv */
`include "hdc_defines.svh"

package hdc_pkg;

    // one hypervector
    typedef logic [`HDC_DIM-1:0] hv_t;

    // item memory index, instruction index taken modulo depth
    typedef logic [$clog2(`HDC_ITEMS)-1:0] item_idx_t;

    // instruction word
    // upper half one-hot op field, lower half item index
    typedef struct packed {
        logic [15:0] op_bits;
        logic [15:0] idx;
    } instr_t;

    // decoded operation
    typedef enum logic [3:0] {
        op_none,
        op_load,
        op_perm_load,
        op_perm_acc,
        op_xor_load,
        op_xor_held,
        op_store,
        op_copy,
        op_invalid
    } op_e;

endpackage

/* logic/hdc_fifo.sv */
`timescale 1ns/1ps

module hdc_fifo #(
    parameter type entry_t = logic [31:0],
    parameter int depth = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           push,
    input  logic                           pop,
    input  entry_t                         wdata,
    output entry_t                         rdata,
    output logic                           empty,
    output logic                           full,
    output logic [$clog2(depth+1)-1:0]     count
);

    localparam int aw = (depth > 1) ? $clog2(depth) : 1;

    // storage, no reset on payload
    entry_t mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_ptr;

    // wrap at depth, depth need not be a power of two
    function automatic logic [aw-1:0] next_ptr(logic [aw-1:0] p);
        return (p == aw'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            // occupancy moves only on push xor pop
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= wdata;
    end

    // head shown without a read cycle
    assign rdata = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == ($clog2(depth+1))'(depth));

    // producers must check full, consumers must check empty
    assert property (@(posedge clk) disable iff (reset) !(push && full));
    assert property (@(posedge clk) disable iff (reset) !(pop && empty));

endmodule

/* logic/hdc_item_memory.sv */
`timescale 1ns/1ps
`include "hdc_defines.svh"

module hdc_item_memory (
    input  logic                clk,
    input  logic                wr_en,
    input  hdc_pkg::item_idx_t  wr_idx,
    input  hdc_pkg::hv_t        wr_data,
    input  logic                rd_en,
    input  hdc_pkg::item_idx_t  rd_idx,
    output hdc_pkg::hv_t        rd_data
);

    import hdc_pkg::*;

    // one hypervector per item, host loaded
    hv_t mem [`HDC_ITEMS];

    // write port from the bus side
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_idx] <= wr_data;
    end

    // registered read for decode
    // data valid the cycle after rd_en
    // holds its value while idle
    always_ff @(posedge clk) begin
        if (rd_en)
            rd_data <= mem[rd_idx];
    end

    // host commits and the instruction stream
    // must not touch the same item together
    assert property (@(posedge clk) !(wr_en && rd_en && (wr_idx == rd_idx)));

endmodule

/* logic/hdc_wb_regs.sv */
`timescale 1ns/1ps
`include "hdc_defines.svh"

module hdc_wb_regs (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cyc,
    input  logic                              stb,
    input  logic                              we,
    input  logic [7:0]                        adr,
    input  logic [31:0]                       dat_w,
    input  logic [3:0]                        sel,
    input  logic                              instr_full,
    input  logic [31:0]                       result_word,
    input  logic                              result_avail,
    input  logic                              instr_empty,
    output logic                              ack,
    output logic [31:0]                       dat_r,
    output logic                              run,
    output logic                              instr_push,
    output hdc_pkg::instr_t                   instr_wdata,
    output logic                              mem_wr_en,
    output hdc_pkg::item_idx_t                mem_wr_idx,
    output hdc_pkg::hv_t                      mem_wr_data,
    output logic [$clog2(`HDC_WORDS)-1:0]     result_sel,
    output logic                              result_read
);

    import hdc_pkg::*;

    localparam int word_w = $clog2(`HDC_WORDS);
    // byte span of one vector window
    localparam logic [7:0] win_mask = 8'(4 * `HDC_WORDS - 1);

    hv_t stage;
    item_idx_t item_sel;
    logic req, accept, instr_wr;
    logic is_stage, is_result, is_commit;
    logic [word_w-1:0] word_idx;
    logic [31:0] rd_val;

    // byte-lane merge for partial writes
    function automatic logic [31:0] merge_bytes(logic [31:0] old_val,
                                                logic [31:0] new_val,
                                                logic [3:0] be);
        logic [31:0] r;
        r = old_val;
        for (int i = 0; i < 4; i++) begin
            if (be[i])
                r[8*i +: 8] = new_val[8*i +: 8];
        end
        return r;
    endfunction

    // address decode
    assign word_idx  = adr[word_w+1:2];
    assign is_stage  = ((adr & ~win_mask) == `HDC_A_STAGE);
    assign is_result = ((adr & ~win_mask) == `HDC_A_RESULT);
    assign is_commit = (adr == `HDC_A_COMMIT);

    // new request, ignored during the ack cycle
    assign req      = cyc && stb && !ack;
    assign instr_wr = req && we && (adr == `HDC_A_INSTR);
    // INSTR write waits here while the queue is full
    assign accept   = req && !(instr_wr && instr_full);

    assign instr_push  = instr_wr && !instr_full;
    assign instr_wdata = instr_t'(dat_w);

    // commit copies the whole staging buffer
    assign mem_wr_en   = accept && we && is_commit;
    assign mem_wr_idx  = item_sel;
    assign mem_wr_data = stage;

    // result pops on last word, decided in hdc_result
    assign result_sel  = word_idx;
    assign result_read = accept && !we && is_result;

    // read mux
    always_comb begin
        rd_val = '0;
        if (is_stage)
            rd_val = stage[word_idx*32 +: 32];
        else if (is_result)
            rd_val = result_word;
        else begin
            case (adr)
                `HDC_A_CTRL:     rd_val = {31'b0, run};
                `HDC_A_ITEM_SEL: rd_val = 32'(item_sel);
                `HDC_A_STATUS:   rd_val = {29'b0, instr_full, instr_empty, result_avail};
                default:         rd_val = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack      <= 1'b0;
            run      <= 1'b0;
            item_sel <= '0;
        end else begin
            ack <= accept;
            if (accept && we && sel[0]) begin
                if (adr == `HDC_A_CTRL)
                    run <= dat_w[0];
                if (adr == `HDC_A_ITEM_SEL)
                    item_sel <= dat_w[$bits(item_idx_t)-1:0];
            end
        end
    end

    // staging buffer and read data, no reset
    always_ff @(posedge clk) begin
        if (accept && we && is_stage)
            stage[word_idx*32 +: 32] <= merge_bytes(stage[word_idx*32 +: 32], dat_w, sel);
        if (accept && !we)
            dat_r <= rd_val;
    end

    // single-cycle ack per access
    assert property (@(posedge clk) disable iff (reset) ack |=> !ack);

endmodule

/* logic/hdc_decode.sv */
`timescale 1ns/1ps

module hdc_decode (
    input  logic                clk,
    input  logic                reset,
    input  logic                run,
    input  logic                instr_valid,
    input  hdc_pkg::instr_t     instr_data,
    input  hdc_pkg::hv_t        mem_rd_data,
    input  logic                result_full,
    output logic                instr_pop,
    output logic                mem_rd_en,
    output hdc_pkg::item_idx_t  mem_rd_idx,
    output logic                op_valid,
    output hdc_pkg::op_e        op,
    output hdc_pkg::hv_t        operand
);

    import hdc_pkg::*;

    op_e head_op;
    logic store_s2;
    logic store_in_flight;

    // lowest set bit wins, nothing in bits 6..0 is invalid
    function automatic op_e decode_op(logic [15:0] bits);
        op_e r;
        r = op_invalid;
        if (bits[0])
            r = op_load;
        else if (bits[1])
            r = op_perm_load;
        else if (bits[2])
            r = op_perm_acc;
        else if (bits[3])
            r = op_xor_load;
        else if (bits[4])
            r = op_xor_held;
        else if (bits[5])
            r = op_store;
        else if (bits[6])
            r = op_copy;
        return r;
    endfunction

    assign head_op = decode_op(instr_data.op_bits);

    // stores between pop and the result queue
    // cycle 1 is op_valid, cycle 2 is store_valid in execute
    assign store_in_flight = (op_valid && (op == op_store)) || store_s2;

    // hold off while halted or the result queue could overflow
    assign instr_pop  = run && instr_valid && !result_full && !store_in_flight;
    // item read in the pop cycle, index modulo memory depth
    assign mem_rd_en  = instr_pop;
    assign mem_rd_idx = item_idx_t'(instr_data.idx);

    // memory read register already lines up with op_valid
    assign operand = mem_rd_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            op_valid <= 1'b0;
            op       <= op_none;
            store_s2 <= 1'b0;
        end else begin
            op_valid <= instr_pop;
            op       <= instr_pop ? head_op : op_none;
            store_s2 <= op_valid && (op == op_store);
        end
    end

endmodule

/* logic/hdc_execute.sv */
`timescale 1ns/1ps

module hdc_execute (
    input  logic           clk,
    input  logic           reset,
    input  logic           run,
    input  logic           op_valid,
    input  hdc_pkg::op_e   op,
    input  hdc_pkg::hv_t   operand,
    output logic           store_valid,
    output hdc_pkg::hv_t   store_data
);

    import hdc_pkg::*;

    // accumulator and held vector
    hv_t acc;
    hv_t held;

    // permutation by one step toward bit 0
    // bit 0 wraps to the top
    function automatic hv_t rotr1(hv_t v);
        return {v[0], v[$bits(hv_t)-1:1]};
    endfunction

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            // halted state drops both vectors
            acc         <= '0;
            held        <= '0;
            store_valid <= 1'b0;
        end else begin
            store_valid <= op_valid && (op == op_store);
            if (op_valid) begin
                case (op)
                    op_load:      acc <= operand;
                    op_perm_load: acc <= rotr1(operand);
                    op_perm_acc:  acc <= rotr1(acc);
                    op_xor_load:  acc <= acc ^ operand;
                    op_xor_held:  acc <= acc ^ held;
                    // snapshot acc for later binding
                    op_copy:      held <= acc;
                    op_invalid: begin
                        acc  <= '0;
                        held <= '0;
                    end
                    // store and none leave state alone
                    default: begin
                        acc  <= acc;
                        held <= held;
                    end
                endcase
            end
        end
    end

    // stored vector valid with store_valid
    always_ff @(posedge clk) begin
        if (op_valid && (op == op_store))
            store_data <= acc;
    end

    // decode spaces stores so no new store meets the one being emitted
    assert property (@(posedge clk) disable iff (reset)
        store_valid |-> !(op_valid && (op == op_store)));

endmodule

/* logic/hdc_result.sv */
`timescale 1ns/1ps
`include "hdc_defines.svh"

module hdc_result (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              store_valid,
    input  hdc_pkg::hv_t                      store_data,
    input  logic [$clog2(`HDC_WORDS)-1:0]     word_sel,
    input  logic                              read,
    output logic [31:0]                       word,
    output logic                              avail,
    output logic                              full
);

    import hdc_pkg::*;

    localparam int word_w = $clog2(`HDC_WORDS);
    localparam logic [word_w-1:0] last_word = word_w'(`HDC_WORDS - 1);

    hv_t head;
    logic empty;
    logic pop;

    // result queue, decode keeps it from overflowing
    hdc_fifo #(
        .entry_t (hv_t),
        .depth   (`HDC_RESULT_DEPTH)
    ) u_queue (
        .clk   (clk),
        .reset (reset),
        .push  (store_valid),
        .pop   (pop),
        .wdata (store_data),
        .rdata (head),
        .empty (empty),
        .full  (full),
        .count ()
    );

    assign avail = !empty;

    // reading the top word retires the head
    // reads with nothing queued pop nothing
    assign pop = read && avail && (word_sel == last_word);

    // slice of head, zero when idle
    assign word = avail ? head[word_sel*32 +: 32] : 32'b0;

endmodule

/* logic/hdc_encoder_top.sv */
`timescale 1ns/1ps
`include "hdc_defines.svh"

module hdc_encoder_top (
    input  logic         clk,
    input  logic         reset,
    input  logic         cyc,
    input  logic         stb,
    input  logic         we,
    input  logic [7:0]   adr,
    input  logic [31:0]  dat_w,
    input  logic [3:0]   sel,
    output logic         ack,
    output logic [31:0]  dat_r
);

    import hdc_pkg::*;

    // bus side
    logic run;
    logic instr_push, instr_pop, instr_full, instr_empty;
    instr_t instr_wdata, instr_head;
    logic mem_wr_en;
    item_idx_t mem_wr_idx;
    hv_t mem_wr_data;
    // decode and execute side
    logic mem_rd_en;
    item_idx_t mem_rd_idx;
    hv_t mem_rd_data, operand;
    logic op_valid;
    op_e op;
    logic store_valid;
    hv_t store_data;
    // result side
    logic [$clog2(`HDC_WORDS)-1:0] result_sel;
    logic result_read, result_avail, result_full;
    logic [31:0] result_word;

    hdc_wb_regs u_regs (
        .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .sel(sel), .instr_full(instr_full), .result_word(result_word),
        .result_avail(result_avail), .instr_empty(instr_empty), .ack(ack),
        .dat_r(dat_r), .run(run), .instr_push(instr_push), .instr_wdata(instr_wdata),
        .mem_wr_en(mem_wr_en), .mem_wr_idx(mem_wr_idx), .mem_wr_data(mem_wr_data),
        .result_sel(result_sel), .result_read(result_read)
    );

    // instruction queue
    hdc_fifo #(
        .entry_t (instr_t),
        .depth   (`HDC_INSTR_DEPTH)
    ) u_instr_q (
        .clk(clk), .reset(reset), .push(instr_push), .pop(instr_pop),
        .wdata(instr_wdata), .rdata(instr_head), .empty(instr_empty),
        .full(instr_full), .count()
    );

    hdc_item_memory u_items (
        .clk(clk), .wr_en(mem_wr_en), .wr_idx(mem_wr_idx), .wr_data(mem_wr_data),
        .rd_en(mem_rd_en), .rd_idx(mem_rd_idx), .rd_data(mem_rd_data)
    );

    hdc_decode u_decode (
        .clk(clk), .reset(reset), .run(run), .instr_valid(!instr_empty),
        .instr_data(instr_head), .mem_rd_data(mem_rd_data), .result_full(result_full),
        .instr_pop(instr_pop), .mem_rd_en(mem_rd_en), .mem_rd_idx(mem_rd_idx),
        .op_valid(op_valid), .op(op), .operand(operand)
    );

    hdc_execute u_execute (
        .clk(clk), .reset(reset), .run(run), .op_valid(op_valid), .op(op),
        .operand(operand), .store_valid(store_valid), .store_data(store_data)
    );

    hdc_result u_result (
        .clk(clk), .reset(reset), .store_valid(store_valid), .store_data(store_data),
        .word_sel(result_sel), .read(result_read), .word(result_word),
        .avail(result_avail), .full(result_full)
    );

endmodule

/* verif/hdc_encoder_tb.sv */
`timescale 1ns/1ps
`include "hdc_defines.svh"

module hdc_encoder_tb;

    import hdc_pkg::*;

    // instruction op field bit numbers
    // bit 7 alone decodes as invalid
    localparam int bit_load = 0;
    localparam int bit_perm_load = 1;
    localparam int bit_perm_acc = 2;
    localparam int bit_xor_load = 3;
    localparam int bit_xor_held = 4;
    localparam int bit_store = 5;
    localparam int bit_copy = 6;
    localparam int bit_bad = 7;
    // several times the cycles all tests take
    localparam int max_cycles = 4000;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic cyc = 1'b0;
    logic stb = 1'b0;
    logic we = 1'b0;
    logic [7:0] adr = 8'h00;
    logic [31:0] dat_w = 32'h0;
    logic [3:0] sel = 4'h0;
    logic ack;
    logic [31:0] dat_r;

    int unsigned cycles = 0;
    integer seed = 32'h7d9add9c;
    // high while a blocked INSTR write must stay unacknowledged
    logic stall_window = 1'b0;
    // shadow state of the encoder
    hv_t items [`HDC_ITEMS];
    hv_t m_acc = '0;
    hv_t m_held = '0;
    hv_t expected [$];

    hdc_encoder_top DUT (
        .clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .sel(sel), .ack(ack), .dat_r(dat_r)
    );

    always #20 clk = ~clk;

    task automatic stop_failed(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles)
            stop_failed("timeout, the run did not finish within the cycle limit");
    end

    // every ack answers a live request
    assert property (@(posedge clk) disable iff (reset) ack |-> $past(cyc && stb))
        else stop_failed("ack seen without a bus request in the previous cycle");
    // full queue with run low must hold the write off
    assert property (@(posedge clk) disable iff (reset) stall_window |-> !ack)
        else stop_failed("INSTR write acknowledged while the queue was full and run low");

    // waits on falling edges between driving edges
    task automatic wait_ack();
        do
            @(negedge clk);
        while (!ack);
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= 1'b1;
        adr <= addr;
        dat_w <= data;
        sel <= 4'hf;
        wait_ack();
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= 1'b0;
        adr <= addr;
        sel <= 4'hf;
        wait_ack();
        data = dat_r;
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    // run low also wipes acc and held
    task automatic set_run(input logic v);
        bus_write(`HDC_A_CTRL, {31'b0, v});
        if (!v) begin
            m_acc = '0;
            m_held = '0;
        end
    endtask

    // stage word by word and commit at ITEM_SEL
    task automatic commit_item(input int idx);
        bus_write(`HDC_A_ITEM_SEL, 32'(idx));
        for (int k = 0; k < `HDC_WORDS; k++)
            bus_write(8'(`HDC_A_STAGE + 4 * k), items[idx][32*k +: 32]);
        bus_write(`HDC_A_COMMIT, 32'h0);
    endtask

    // shadow execution of one op
    task automatic model_op(input int bit_n, input int idx);
        hv_t opnd;
        opnd = items[idx % `HDC_ITEMS];
        case (bit_n)
            bit_load:      m_acc = opnd;
            bit_perm_load: m_acc = {opnd[0], opnd[`HDC_DIM-1:1]};
            bit_perm_acc:  m_acc = {m_acc[0], m_acc[`HDC_DIM-1:1]};
            bit_xor_load:  m_acc = m_acc ^ opnd;
            bit_xor_held:  m_acc = m_acc ^ m_held;
            bit_store:     expected.push_back(m_acc);
            bit_copy:      m_held = m_acc;
            default: begin
                m_acc = '0;
                m_held = '0;
            end
        endcase
    endtask

    task automatic issue(input int bit_n, input int idx);
        model_op(bit_n, idx);
        bus_write(`HDC_A_INSTR, {16'(1 << bit_n), 16'(idx)});
    endtask

    // poll STATUS until a result waits
    // then read and compare all words of the head result
    task automatic check_result();
        logic [31:0] st;
        logic [31:0] got;
        hv_t exp;
        do
            bus_read(`HDC_A_STATUS, st);
        while (!st[0]);
        assert (expected.size() > 0)
            else stop_failed("a result became available with none expected");
        exp = expected.pop_front();
        for (int k = 0; k < `HDC_WORDS; k++) begin
            bus_read(8'(`HDC_A_RESULT + 4 * k), got);
            assert (got == exp[32*k +: 32])
                else stop_failed($sformatf(
                    "MISMATCH time=%0t dat_r (RESULT word %0d) got %h expected %h",
                    $time, k, got, exp[32*k +: 32]));
        end
    endtask

    initial begin
        logic [31:0] st;
        logic [31:0] got;
        for (int i = 0; i < 8; i++)
            for (int k = 0; k < `HDC_WORDS; k++)
                items[i][32*k +: 32] = $random(seed);
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // idle state after reset
        bus_read(`HDC_A_STATUS, st);
        assert (st[2:0] == 3'b010)
            else stop_failed($sformatf(
                "MISMATCH time=%0t dat_r (STATUS) got %h expected %h",
                $time, st[2:0], 3'b010));
        bus_read(`HDC_A_RESULT, got);
        assert (got == 32'h0)
            else stop_failed($sformatf(
                "MISMATCH time=%0t dat_r (RESULT word 0) got %h expected %h",
                $time, got, 32'h0));

        // items go in while halted so no read meets a commit
        for (int i = 0; i < 8; i++)
            commit_item(i);
        set_run(1'b1);

        // plain load and store
        // index 66 wraps to item 2
        for (int i = 0; i < 4; i++) begin
            issue(bit_load, (i == 2) ? i + `HDC_ITEMS : i);
            issue(bit_store, 0);
            check_result();
        end

        // trigram of items 4, 5, 6
        issue(bit_perm_load, 4);
        issue(bit_perm_acc, 0);
        issue(bit_perm_acc, 0);
        issue(bit_xor_load, 5);
        issue(bit_perm_acc, 0);
        issue(bit_xor_load, 6);
        issue(bit_store, 0);
        check_result();

        // bind through held
        issue(bit_load, 1);
        issue(bit_copy, 0);
        issue(bit_load, 7);
        issue(bit_xor_held, 0);
        issue(bit_store, 0);
        check_result();
        // an invalid word then clears everything
        issue(bit_bad, 3);
        issue(bit_store, 0);
        check_result();

        // four writes fill the instruction queue while halted
        set_run(1'b0);
        for (int i = 0; i < 4; i++)
            issue(bit_load, 3 + `HDC_ITEMS);
        bus_read(`HDC_A_STATUS, st);
        assert (st[2:1] == 2'b10)
            else stop_failed($sformatf(
                "MISMATCH time=%0t dat_r (STATUS queue bits) got %h expected %h",
                $time, st[2:1], 2'b10));
        // fifth write waits 20 cycles before the host abandons it
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we <= 1'b1;
        adr <= `HDC_A_INSTR;
        dat_w <= {16'(1 << bit_store), 16'h0};
        stall_window <= 1'b1;
        repeat (20) @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we <= 1'b0;
        // an ack for the last request cycle would show one edge later
        @(posedge clk);
        stall_window <= 1'b0;
        // with run set the queue drains and the retry goes through
        set_run(1'b1);
        issue(bit_store, 0);
        check_result();

        // four stores against a two-entry result queue
        // acc rotates between stores so the order shows
        issue(bit_load, 5);
        for (int i = 0; i < 4; i++) begin
            if (i > 0)
                issue(bit_perm_acc, 0);
            issue(bit_store, 0);
        end
        for (int i = 0; i < 4; i++)
            check_result();

        if (expected.size() != 0) begin
            stop_failed("expected results were never returned");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

/* hdc_encoder.f */
+incdir+include
logic/hdc_pkg.sv
logic/hdc_fifo.sv
logic/hdc_item_memory.sv
logic/hdc_wb_regs.sv
logic/hdc_decode.sv
logic/hdc_execute.sv
logic/hdc_result.sv
logic/hdc_encoder_top.sv
verif/hdc_encoder_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the encoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module hdc_encoder_tb \
    -f hdc_encoder.f \
    -o hdc_encoder_sim

./obj_dir/hdc_encoder_sim
